// ==== verilog.f ====
+incdir+rtl
rtl/opl_synth_pkg.sv
rtl/opl_reg_pkg.sv
rtl/opl_host_if.sv
rtl/opl_timers.sv
rtl/opl_sequencer.sv
rtl/opl_operator.sv
rtl/opl_top.sv
sim/opl_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# build and run the opl testbench with verilator

cd "$(dirname "$0")" || exit 1
LOG=sim.log

verilator --binary --timing --assert -Wno-fatal \
    -f verilog.f --top-module opl_tb -o opl_sim
if [ $? -ne 0 ]; then
    echo "build failed"
    exit 1
fi

./obj_dir/opl_sim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "^Verification passed$" "$LOG"; then
    exit 0
fi
echo "pass message not found in $LOG"
exit 1

// ==== sim/opl_tb.sv ====
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// opl tone generator testbench
// host writes, reference model of the
// operator sum, credit back-pressure, timers
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`default_nettype none
`include "opl_config.svh"

module opl_tb;
    import opl_reg_pkg::*;
    import opl_synth_pkg::*;

    localparam int DIV            = `OPL_SAMPLE_DIV;
    localparam int CREDITS        = `OPL_SAMPLE_CREDITS;
    localparam int NCH            = `OPL_NUM_CHANNELS;
    localparam int PW             = `OPL_PHASE_WIDTH;
    localparam int PHASE_MASK     = (1 << PW) - 1;
    localparam int TEST_TICKS     = 100;                     // all five tests together
    localparam int TIMEOUT_CYCLES = TEST_TICKS * DIV * 2 + 20;

    logic       clk;
    logic       rst_n;
    logic       cs_n;
    logic       wr_n;
    logic       rd_n;
    logic       address;
    logic [7:0] din;
    logic [7:0] dout;
    logic       sample_valid;
    sample_t    sample;
    logic       credit_return;
    logic       irq_n;

    int          errors      = 0;
    int          pass_count  = 0;
    int          fail_count  = 0;
    int          issued      = 0;   // samples seen by the monitor
    int          outstanding = 0;   // samples not yet credited back
    logic [31:0] lfsr        = 32'hdf63;

    // reference model state per channel
    int m_phase [NCH];
    int m_fnum  [NCH];
    int m_block [NCH];
    int m_tl    [NCH];
    bit m_kon   [NCH];
    bit m_saw   [NCH];

    opl_top DUT (
        .clk           (clk),
        .rst_n         (rst_n),
        .cs_n          (cs_n),
        .wr_n          (wr_n),
        .rd_n          (rd_n),
        .address       (address),
        .din           (din),
        .dout          (dout),
        .sample_valid  (sample_valid),
        .sample        (sample),
        .credit_return (credit_return),
        .irq_n         (irq_n)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    initial begin
        repeat (TIMEOUT_CYCLES) @(posedge clk);
        $display("Timeout: run did not finish within %0d clocks", TIMEOUT_CYCLES);
        $display("Verification failed");
        $finish;
    end

    // credit bookkeeping at the falling edge
    always @(negedge clk) begin
        if (!rst_n) begin
            issued      = 0;
            outstanding = 0;
        end else begin
            if (sample_valid) begin
                issued++;
            end
            outstanding = outstanding + int'(sample_valid) - int'(credit_return);
            assert (outstanding >= 0 && outstanding <= CREDITS) else begin
                $display("Credit overrun: %0d samples outstanding, limit %0d",
                         outstanding, CREDITS);
                errors++;
            end
        end
    end

    valid_pulse: assert property (@(posedge clk) disable iff (!rst_n)
                                  sample_valid |=> !sample_valid)
        else begin
            $display("sample_valid stayed high for more than one clock");
            errors++;
        end

    // fibonacci lfsr with taps 32 22 2 1
    function automatic logic next_bit();
        logic fb;
        fb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
        lfsr = {lfsr[30:0], fb};
        return fb;
    endfunction

    function automatic int draw_bits(input int n);
        int v;
        v = 0;
        for (int i = 0; i < n; i++) begin
            v = (v << 1) | int'(next_bit());
        end
        return v;
    endfunction

    // sums one pass over all channels and advances the model phases
    function automatic int model_sample();
        int sum;
        int raw;
        sum = 0;
        for (int ch = 0; ch < NCH; ch++) begin
            if (!m_kon[ch]) begin
                m_phase[ch] = 0;                           // silent and parked
            end else begin
                if (m_saw[ch]) begin
                    raw = (m_phase[ch] >> (PW - 12)) & 'hfff;  // top 12 phase bits
                    if (raw >= 2048) begin
                        raw = raw - 4096;
                    end
                end else begin
                    raw = (m_phase[ch] & (1 << (PW - 1))) != 0 ?
                          -`OPL_FULL_SCALE : `OPL_FULL_SCALE;
                end
                sum = sum + (raw >>> m_tl[ch]);            // floor shift
                m_phase[ch] = (m_phase[ch] + (m_fnum[ch] << m_block[ch])) & PHASE_MASK;
            end
        end
        return sum;
    endfunction

    task automatic next_cycle();
        @(posedge clk);
        #10;
    endtask

    task automatic check_val(input string name, input int exp, input int act);
        assert (exp == act) else begin
            $display("Mismatch %s: expected %0d, actual %0d", name, exp, act);
            errors++;
        end
    endtask

    task automatic write_reg(input logic [7:0] idx, input logic [7:0] data);
        cs_n    = 1'b0;
        wr_n    = 1'b0;
        address = 1'b0;     // index strobe
        din     = idx;
        next_cycle();
        address = 1'b1;     // data strobe
        din     = data;
        next_cycle();
        cs_n    = 1'b1;
        wr_n    = 1'b1;
    endtask

    task automatic read_status(output int st);
        cs_n = 1'b0;
        rd_n = 1'b0;
        #5;
        st = int'(dout);
        next_cycle();
        cs_n = 1'b1;
        rd_n = 1'b1;
    endtask

    task automatic return_credit();
        credit_return = 1'b1;
        next_cycle();
        credit_return = 1'b0;
    endtask

    task automatic set_channel(input int ch, input bit kon, input int block,
                               input int fnum, input int tl, input bit saw);
        logic [7:0] bk;
        bk = {2'b00, kon, 3'(block), 2'(fnum >> 8)};
        write_reg(8'(int'(REG_TL_BASE) + ch), 8'(tl));
        write_reg(8'(int'(REG_FNUM_LO_BASE) + ch), 8'(fnum));
        write_reg(8'(int'(REG_WS_BASE) + ch), {7'd0, saw});
        write_reg(8'(int'(REG_BLOCK_KON_BASE) + ch), bk);  // key-on last
        m_kon[ch]   = kon;
        m_block[ch] = block;
        m_fnum[ch]  = fnum;
        m_tl[ch]    = tl;
        m_saw[ch]   = saw;
        if (!kon) begin
            m_phase[ch] = 0;
        end
    endtask

    // waits for one sample, checks it, optionally frees its slot
    task automatic get_sample(input string name, input bit give_credit);
        int waited;
        int act;
        waited = 0;
        while (!sample_valid && waited < 3 * DIV) begin
            next_cycle();
            waited++;
        end
        if (!sample_valid) begin
            $display("%s: no sample arrived within %0d clocks", name, 3 * DIV);
            errors++;
        end else begin
            act = sample.value;
            check_val(name, model_sample(), act);
        end
        credit_return = give_credit;
        next_cycle();
        credit_return = 1'b0;
    endtask

    task automatic finish_test(input string name, input int base);
        if (errors == base) begin
            pass_count++;
            $display("test %s: passed", name);
        end else begin
            fail_count++;
            $display("test %s: failed with %0d errors", name, errors - base);
        end
    endtask

    initial begin
        int base;
        int st;
        int gap;
        int issued_start;
        int waited;
        cs_n          = 1'b1;
        wr_n          = 1'b1;
        rd_n          = 1'b1;
        address       = 1'b0;
        din           = 8'h00;
        credit_return = 1'b0;
        rst_n         = 1'b0;
        repeat (10) @(posedge clk);
        #10;
        rst_n = 1'b1;

        // reset state with silent channels
        base = errors;
        read_status(st);
        check_val("reset status", 0, st);
        check_val("reset irq_n", 1, int'(irq_n));
        repeat (DIV - 8) begin                             // well before the first tick
            assert (!sample_valid) else begin
                $display("sample_valid high before the first sample tick");
                errors++;
            end
            next_cycle();
        end
        repeat (3) get_sample("reset silence", 1'b1);
        finish_test("reset", base);

        // random tones with square on even and saw on odd channels
        base = errors;
        for (int ch = 0; ch < NCH; ch++) begin
            set_channel(ch, 1'b1, draw_bits(3), draw_bits(10), draw_bits(2), ch % 2 == 1);
        end
        repeat (32) get_sample("waves", 1'b1);
        finish_test("waves", base);

        // consumer stalls and then frees slots at random gaps
        base         = errors;
        issued_start = issued;
        repeat (CREDITS) get_sample("backpressure", 1'b0);
        repeat (6 * DIV) next_cycle();
        check_val("backpressure count", CREDITS, issued - issued_start);
        repeat (8) begin
            gap = draw_bits(3) + 1;
            repeat (gap) next_cycle();
            return_credit();
            get_sample("credit resume", 1'b0);
        end
        repeat (CREDITS) return_credit();
        finish_test("backpressure", base);

        // key-off and key-on of channel 1
        base = errors;
        get_sample("keyoff sync", 1'b1);                   // lands right after a pass
        set_channel(1, 1'b0, m_block[1], m_fnum[1], m_tl[1], m_saw[1]);
        repeat (4) get_sample("keyoff", 1'b1);
        set_channel(1, 1'b1, m_block[1], m_fnum[1], m_tl[1], m_saw[1]);
        repeat (4) get_sample("keyon restart", 1'b1);
        finish_test("keyoff", base);

        // timer 1 overflow and masked timer 2 then irq reset
        base = errors;
        write_reg(REG_TIMER1, 8'hfc);
        write_reg(REG_TIMER2, 8'hff);
        write_reg(REG_TIMER_CTRL, 8'h23);                  // st1, st2, mask2
        waited = 0;
        while (irq_n && waited < 8 * DIV) begin
            next_cycle();
            waited++;
        end
        if (irq_n) begin
            $display("timer 1 overflow never drove irq_n low");
            errors++;
        end
        read_status(st);
        check_val("timer1 status", 'hc0, st);
        repeat (16) begin                                  // four timer 2 overflows
            repeat (DIV) next_cycle();
            read_status(st);
            check_val("timer2 masked", 0, st & 'h20);
        end
        write_reg(REG_TIMER_CTRL, 8'h22);                  // timer 1 stopped
        write_reg(REG_TIMER_CTRL, 8'h80);                  // flag clear
        next_cycle();
        check_val("irq_n after irq reset", 1, int'(irq_n));
        read_status(st);
        check_val("status after irq reset", 0, st);
        finish_test("timers", base);

        $display("tests: %0d passed, %0d failed", pass_count, fail_count);
        if (fail_count == 0 && errors == 0) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== rtl/opl_top.sv ====
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// opl tone generator top level
// host port, timers, channel sequencer
// and operator datapath
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`default_nettype none
`include "opl_config.svh"

module opl_top (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   cs_n,
    input  logic                   wr_n,
    input  logic                   rd_n,
    input  logic                   address,
    input  logic [7:0]             din,
    output logic [7:0]             dout,
    output logic                   sample_valid,
    output opl_synth_pkg::sample_t sample,
    input  logic                   credit_return,
    output logic                   irq_n
);
    import opl_reg_pkg::*;
    import opl_synth_pkg::*;

    chan_regs_t  chan_regs [`OPL_NUM_CHANNELS];
    logic [7:0]  timer1_preset;
    logic [7:0]  timer2_preset;
    timer_ctrl_t timer_ctrl;
    logic        ctrl_wr;      // pulse per control write
    status_t     status;
    logic        sample_tick;
    logic [$clog2(`OPL_NUM_CHANNELS)-1:0] chan_sel;
    logic        step;
    op_out_t     op_out;

    opl_host_if u_host_if (
        .clk           (clk),
        .rst_n         (rst_n),
        .cs_n          (cs_n),
        .wr_n          (wr_n),
        .rd_n          (rd_n),
        .address       (address),
        .din           (din),
        .dout          (dout),
        .chan_regs     (chan_regs),
        .timer1_preset (timer1_preset),
        .timer2_preset (timer2_preset),
        .timer_ctrl    (timer_ctrl),
        .ctrl_wr       (ctrl_wr),
        .status        (status)
    );

    opl_timers u_timers (
        .clk           (clk),
        .rst_n         (rst_n),
        .timer1_preset (timer1_preset),
        .timer2_preset (timer2_preset),
        .timer_ctrl    (timer_ctrl),
        .ctrl_wr       (ctrl_wr),
        .sample_tick   (sample_tick),
        .status        (status),
        .irq_n         (irq_n)
    );

    opl_sequencer u_sequencer (
        .clk           (clk),
        .rst_n         (rst_n),
        .sample_tick   (sample_tick),
        .chan_sel      (chan_sel),
        .step          (step),
        .op_out        (op_out),
        .credit_return (credit_return),
        .sample_valid  (sample_valid),
        .sample        (sample)
    );

    opl_operator u_operator (
        .clk           (clk),
        .rst_n         (rst_n),
        .chan_regs     (chan_regs),
        .chan_sel      (chan_sel),
        .step          (step),
        .op_out        (op_out)
    );

endmodule

`default_nettype wire

// ==== rtl/opl_operator.sv ====
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// opl operator
// per-channel phase accumulators, square or
// saw wave, tl shift, one cycle latency
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`default_nettype none
`include "opl_config.svh"

module opl_operator (
    input  logic                                  clk,
    input  logic                                  rst_n,
    input  opl_reg_pkg::chan_regs_t               chan_regs [`OPL_NUM_CHANNELS],
    input  logic [$clog2(`OPL_NUM_CHANNELS)-1:0]  chan_sel,
    input  logic                                  step,
    output opl_synth_pkg::op_out_t                op_out
);
    import opl_reg_pkg::*;
    import opl_synth_pkg::*;

    localparam int CH_W = $clog2(`OPL_NUM_CHANNELS);
    localparam int PW   = `OPL_PHASE_WIDTH;
    localparam int WW   = `OPL_WAVE_WIDTH;
    localparam logic signed [WW-1:0] FULL = WW'(`OPL_FULL_SCALE);

    logic [PW-1:0]        phase [`OPL_NUM_CHANNELS];
    chan_regs_t           sel_regs;
    logic [PW-1:0]        sel_phase;    // value before the add
    logic [PW-1:0]        incr;
    logic signed [WW-1:0] raw;
    logic signed [WW-1:0] shifted;
    logic                 valid_q;
    logic signed [WW-1:0] value_q;

    assign sel_regs  = chan_regs[chan_sel];
    assign sel_phase = phase[chan_sel];
    assign incr      = PW'(sel_regs.fnum) << sel_regs.block;  // fits, no wrap of incr

    always_comb begin
        case (sel_regs.ws)
            WAVE_SQUARE: raw = sel_phase[PW-1] ? -FULL : FULL;
            WAVE_SAW:    raw = $signed(sel_phase[PW-1 -: WW]);  // top bits as signed ramp
            default:     raw = '0;
        endcase
    end

    assign shifted = raw >>> sel_regs.tl;   // arithmetic attenuation

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            valid_q <= 1'b0;
            for (int i = 0; i < `OPL_NUM_CHANNELS; i++) begin
                phase[i] <= '0;
            end
        end else begin
            valid_q <= step;
            for (int i = 0; i < `OPL_NUM_CHANNELS; i++) begin
                if (!chan_regs[i].kon) begin
                    phase[i] <= '0;                     // key-off parks phase at zero
                end else if (step && chan_sel == CH_W'(i)) begin
                    phase[i] <= phase[i] + incr;        // modulo phase width
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        value_q <= sel_regs.kon ? shifted : '0;
    end

    assign op_out = '{valid: valid_q, value: value_q};

endmodule

`default_nettype wire

// ==== rtl/opl_sequencer.sv ====
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// opl channel sequencer
// steps every channel once per tick, sums
// the operator outputs, issues on credit
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`default_nettype none
`include "opl_config.svh"

module opl_sequencer (
    input  logic                                  clk,
    input  logic                                  rst_n,
    input  logic                                  sample_tick,
    output logic [$clog2(`OPL_NUM_CHANNELS)-1:0]  chan_sel,
    output logic                                  step,
    input  opl_synth_pkg::op_out_t                op_out,
    input  logic                                  credit_return,
    output logic                                  sample_valid,
    output opl_synth_pkg::sample_t                sample
);
    import opl_synth_pkg::*;

    localparam int CH_W = $clog2(`OPL_NUM_CHANNELS);
    localparam int SW   = `OPL_SAMPLE_WIDTH;
    localparam int WW   = `OPL_WAVE_WIDTH;
    localparam int CR_W = $clog2(`OPL_SAMPLE_CREDITS + 1);
    localparam logic [CR_W-1:0] CREDIT_MAX = CR_W'(`OPL_SAMPLE_CREDITS);

    seq_state_e           state;
    logic [CR_W-1:0]      credits;
    logic signed [SW-1:0] acc;
    logic signed [SW-1:0] op_ext;
    logic signed [SW-1:0] acc_next;
    logic                 has_credit;
    logic                 issue;

    assign op_ext     = {{(SW - WW){op_out.value[WW-1]}}, op_out.value};  // sign extend
    assign acc_next   = op_out.valid ? acc + op_ext : acc;
    assign has_credit = (credits != '0);
    assign issue      = has_credit && (state == SEQ_DRAIN || state == SEQ_HOLD);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state        <= SEQ_IDLE;
            chan_sel     <= '0;
            step         <= 1'b0;
            sample_valid <= 1'b0;
        end else begin
            sample_valid <= issue;
            case (state)
                SEQ_IDLE: begin
                    if (sample_tick) begin                  // ticks elsewhere dropped
                        state    <= SEQ_RUN;
                        chan_sel <= '0;
                        step     <= 1'b1;
                    end
                end
                SEQ_RUN: begin
                    if (chan_sel == CH_W'(`OPL_NUM_CHANNELS - 1)) begin
                        state <= SEQ_DRAIN;
                        step  <= 1'b0;
                    end else begin
                        chan_sel <= chan_sel + 1'b1;
                    end
                end
                SEQ_DRAIN: state <= issue ? SEQ_IDLE : SEQ_HOLD;
                SEQ_HOLD:  if (issue) state <= SEQ_IDLE;
                default:   state <= SEQ_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        acc <= (state == SEQ_IDLE) ? '0 : acc_next;   // cleared between passes
        if (issue) begin
            sample <= '{value: acc_next};
        end
    end

    // return and issue in one cycle cancel
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            credits <= CREDIT_MAX;
        end else if (issue && !credit_return) begin
            credits <= credits - 1'b1;
        end else if (credit_return && !issue && credits != CREDIT_MAX) begin
            credits <= credits + 1'b1;                  // saturate at max
        end
    end

endmodule

`default_nettype wire

// ==== rtl/opl_timers.sv ====
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// opl timers
// sample tick divider plus two 8-bit
// overflow timers with flags and irq
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`default_nettype none
`include "opl_config.svh"

module opl_timers (
    input  logic                     clk,
    input  logic                     rst_n,
    input  logic [7:0]               timer1_preset,
    input  logic [7:0]               timer2_preset,
    input  opl_reg_pkg::timer_ctrl_t timer_ctrl,
    input  logic                     ctrl_wr,
    output logic                     sample_tick,
    output opl_reg_pkg::status_t     status,
    output logic                     irq_n
);
    import opl_reg_pkg::*;

    localparam int DIV_W = $clog2(`OPL_SAMPLE_DIV);

    logic [DIV_W-1:0] div_cnt;
    logic [1:0]       t2_pre;     // timer 2 runs at quarter rate
    logic             restart;
    logic [7:0]       preset [2];
    logic             start  [2];
    logic             mask   [2];
    logic             t_tick [2];
    logic [7:0]       cnt    [2];
    logic             flag   [2];

    assign restart   = ctrl_wr && !timer_ctrl.irq_rst;
    assign preset[0] = timer1_preset;
    assign preset[1] = timer2_preset;
    assign start[0]  = timer_ctrl.st1;
    assign start[1]  = timer_ctrl.st2;
    assign mask[0]   = timer_ctrl.mask1;
    assign mask[1]   = timer_ctrl.mask2;
    assign t_tick[0] = sample_tick;
    assign t_tick[1] = sample_tick && (t2_pre == 2'd3);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            div_cnt     <= '0;
            sample_tick <= 1'b0;
            t2_pre      <= '0;
        end else begin
            sample_tick <= (div_cnt == DIV_W'(`OPL_SAMPLE_DIV - 1));
            div_cnt     <= (div_cnt == DIV_W'(`OPL_SAMPLE_DIV - 1)) ? '0 : div_cnt + 1'b1;
            if (sample_tick) begin
                t2_pre <= t2_pre + 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int t = 0; t < 2; t++) begin
                cnt[t]  <= '0;
                flag[t] <= 1'b0;
            end
        end else begin
            for (int t = 0; t < 2; t++) begin
                if (restart && start[t]) begin
                    cnt[t] <= preset[t];                // load on start
                end else if (start[t] && t_tick[t]) begin
                    if (cnt[t] == 8'hff) begin
                        cnt[t] <= preset[t];            // reload on overflow
                        if (!mask[t]) begin
                            flag[t] <= 1'b1;
                        end
                    end else begin
                        cnt[t] <= cnt[t] + 1'b1;
                    end
                end
                if (ctrl_wr && timer_ctrl.irq_rst) begin
                    flag[t] <= 1'b0;                    // irq reset wins
                end
            end
        end
    end

    assign status = '{irq: flag[0] | flag[1], ft1: flag[0], ft2: flag[1], rsvd: '0};
    assign irq_n  = ~status.irq;

endmodule

`default_nettype wire

// ==== rtl/opl_host_if.sv ====
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// opl host interface
// index latch, channel and timer register
// file, status readback on the data port
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`default_nettype none
`include "opl_config.svh"

module opl_host_if (
    input  logic                     clk,
    input  logic                     rst_n,
    input  logic                     cs_n,
    input  logic                     wr_n,
    input  logic                     rd_n,
    input  logic                     address,  // 0 index, 1 data
    input  logic [7:0]               din,
    output logic [7:0]               dout,
    output opl_reg_pkg::chan_regs_t  chan_regs [`OPL_NUM_CHANNELS],
    output logic [7:0]               timer1_preset,
    output logic [7:0]               timer2_preset,
    output opl_reg_pkg::timer_ctrl_t timer_ctrl,
    output logic                     ctrl_wr,
    input  opl_reg_pkg::status_t     status
);
    import opl_reg_pkg::*;
    import opl_synth_pkg::*;

    localparam int CH_W = $clog2(`OPL_NUM_CHANNELS);

    logic [7:0]      index_q;
    logic [7:0]      base;      // index with channel offset stripped
    logic [CH_W-1:0] ch;
    logic            ch_ok;
    logic            wr_strobe;

    assign wr_strobe = !cs_n && !wr_n;
    assign base      = {index_q[7:4], 4'h0};
    assign ch        = index_q[CH_W-1:0];
    assign ch_ok     = int'(index_q[3:0]) < `OPL_NUM_CHANNELS;  // unused offsets ignored

    assign dout = (!cs_n && !rd_n) ? status : 8'h00;  // read mux

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            index_q       <= '0;
            timer1_preset <= '0;
            timer2_preset <= '0;
            timer_ctrl    <= '0;
            ctrl_wr       <= 1'b0;
            for (int i = 0; i < `OPL_NUM_CHANNELS; i++) begin
                chan_regs[i] <= '0;
            end
        end else begin
            ctrl_wr <= 1'b0;  // single-cycle pulse
            if (wr_strobe && !address) begin
                index_q <= din;
            end
            if (wr_strobe && address) begin
                case (index_q)
                    REG_TIMER1: timer1_preset <= din;
                    REG_TIMER2: timer2_preset <= din;
                    REG_TIMER_CTRL: begin
                        ctrl_wr <= 1'b1;
                        if (din[7]) begin
                            timer_ctrl.irq_rst <= 1'b1;  // flag clear only, rest kept
                        end else begin
                            timer_ctrl <= '{irq_rst: 1'b0, mask1: din[6], mask2: din[5],
                                            st2: din[1], st1: din[0]};
                        end
                    end
                    default: begin
                        if (ch_ok) begin
                            case (base)
                                REG_TL_BASE:      chan_regs[ch].tl <= din[3:0];
                                REG_FNUM_LO_BASE: chan_regs[ch].fnum[7:0] <= din;
                                REG_BLOCK_KON_BASE: begin
                                    chan_regs[ch].kon   <= din[5];
                                    chan_regs[ch].block <= din[4:2];
                                    chan_regs[ch].fnum[`OPL_FNUM_WIDTH-1:8] <= din[1:0];
                                end
                                REG_WS_BASE:      chan_regs[ch].ws <= wave_e'(din[0]);
                                default: ;        // undecoded range
                            endcase
                        end
                    end
                endcase
            end
        end
    end

endmodule

`default_nettype wire

// ==== rtl/opl_reg_pkg.sv ====
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// opl host register types
// register map, per-channel state,
// timer control and status byte
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`default_nettype none
`include "opl_config.svh"

package opl_reg_pkg;

    typedef enum logic [7:0] {
        REG_TIMER1         = 8'h02,
        REG_TIMER2         = 8'h03,
        REG_TIMER_CTRL     = 8'h04,
        REG_TL_BASE        = 8'h40,  // channel i at base + i
        REG_FNUM_LO_BASE   = 8'hA0,
        REG_BLOCK_KON_BASE = 8'hB0,
        REG_WS_BASE        = 8'hE0
    } reg_addr_e;

    typedef struct packed {
        logic                        kon;
        logic [2:0]                  block;  // octave shift
        logic [`OPL_FNUM_WIDTH-1:0]  fnum;
        logic [3:0]                  tl;     // attenuation as right shift
        opl_synth_pkg::wave_e        ws;
    } chan_regs_t;

    typedef struct packed {
        logic irq_rst;  // din[7]
        logic mask1;    // din[6]
        logic mask2;    // din[5]
        logic st2;      // din[1]
        logic st1;      // din[0]
    } timer_ctrl_t;

    typedef struct packed {
        logic       irq;   // bit 7
        logic       ft1;   // bit 6
        logic       ft2;   // bit 5
        logic [4:0] rsvd;  // always zero
    } status_t;

endpackage

`default_nettype wire

// ==== rtl/opl_synth_pkg.sv ====
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// opl datapath types
// sequencer states, waveforms, operator
// result and mixed sample
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`default_nettype none
`include "opl_config.svh"

package opl_synth_pkg;

    typedef enum logic [1:0] {
        SEQ_IDLE,   // waiting for sample tick
        SEQ_RUN,    // stepping channels
        SEQ_DRAIN,  // last operator result in flight
        SEQ_HOLD    // sum ready, no credit
    } seq_state_e;

    typedef enum logic {
        WAVE_SQUARE = 1'b0,
        WAVE_SAW    = 1'b1
    } wave_e;

    typedef struct packed {
        logic                               valid;
        logic signed [`OPL_WAVE_WIDTH-1:0]  value;
    } op_out_t;

    typedef struct packed {
        logic signed [`OPL_SAMPLE_WIDTH-1:0] value;
    } sample_t;

endpackage

`default_nettype wire

// ==== rtl/opl_config.svh ====
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// opl tone generator configuration
// channel count, datapath widths, sample
// divider ratio and output credit depth
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`ifndef OPL_CONFIG_SVH
`define OPL_CONFIG_SVH

`define OPL_NUM_CHANNELS   4      // channels stepped per sample
`define OPL_FNUM_WIDTH     10     // frequency number
`define OPL_PHASE_WIDTH    20     // phase accumulator
`define OPL_WAVE_WIDTH     12     // signed operator output
`define OPL_SAMPLE_WIDTH   16     // signed mixed sample
`define OPL_SAMPLE_DIV     64     // clocks per sample tick
`define OPL_SAMPLE_CREDITS 2      // consumer slots after reset
`define OPL_FULL_SCALE     2047   // square amplitude

`endif
